// ==== include/video_settings.svh ====
// Video output stage settings

`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Colour widths per channel
`define VID_IN_W    4
`define VID_OUT_W   6

// 24 MHz clk_rgb down to 6 MHz pixel rate
`define CEN_DIV     4

// Wishbone slave geometry
`define WB_ADR_W    2
`define WB_DAT_W    8
`define WB_REG_NUM  4   // Address slots, slot 3 reads zero

// Read-only identification byte
`define CORE_ID     8'h47

`endif

// ==== design/video_pkg.sv ====
// Video data types

`default_nettype none

`include "video_settings.svh"

package video_pkg;

    // One widened pixel. For YPbPr, r holds Pr, g holds Y and b holds Pb
    typedef struct packed {
        logic [`VID_OUT_W-1:0] r;
        logic [`VID_OUT_W-1:0] g;
        logic [`VID_OUT_W-1:0] b;
    } rgb6_t;

    // Analog port output format
    typedef enum logic {
        OUT_RGB   = 1'b0,
        OUT_YPBPR = 1'b1
    } out_mode_e;

endpackage

`default_nettype wire

// ==== design/wb_pkg.sv ====
// Wishbone slave types

`default_nettype none

`include "video_settings.svh"

package wb_pkg;

    // Register map, address 3 is unused
    typedef enum logic [`WB_ADR_W-1:0] {
        REG_MODE = 2'd0,
        REG_SYNC = 2'd1,
        REG_ID   = 2'd2
    } reg_addr_e;

    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

endpackage

`default_nettype wire

// ==== design/video_ifs.sv ====
// Pixel and configuration interfaces

`timescale 1ns/1ps
`default_nettype none

// Pixel with its sync pair
interface pix_if;
    video_pkg::rgb6_t pix;
    logic             hs;
    logic             vs;

    modport src (
        output pix,
        output hs,
        output vs
    );

    modport snk (
        input pix,
        input hs,
        input vs
    );
endinterface

// Output configuration switches
interface cfg_if;
    video_pkg::out_mode_e mode;
    logic                 csync_en;
    logic                 blank_en;
    logic                 hs_inv;
    logic                 vs_inv;

    modport regs (
        output mode,
        output csync_en,
        output blank_en,
        output hs_inv,
        output vs_inv
    );

    modport user (
        input mode,
        input csync_en,
        input blank_en,
        input hs_inv,
        input vs_inv
    );
endinterface

`default_nettype wire

// ==== design/cen_div.sv ====
// Pixel clock enable divider

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module cen_div (
    input  wire  clk_rgb,
    input  wire  rst_n_i,
    output logic cen6_o
);

    // Keep at least one counter bit when the ratio is 1
    localparam int CNT_W = (`CEN_DIV > 1) ? $clog2(`CEN_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CEN_DIV - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             cen_q;

    always_ff @(posedge clk_rgb) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            cen_q <= 1'b0;
        end else begin
            cnt_q <= (cnt_q == CNT_LAST) ? '0 : cnt_q + 1'b1;
            cen_q <= (cnt_q == CNT_LAST);    // Strobe for the last count
        end
    end

    assign cen6_o = cen_q;

endmodule

`default_nettype wire

// ==== design/wb_cfg_regs.sv ====
// Wishbone configuration registers

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module wb_cfg_regs (
    input  wire                 clk_rgb,
    input  wire                 rst_n_i,
    input  wire                 wb_cyc_i,
    input  wire                 wb_stb_i,
    input  wire                 wb_we_i,
    input  wire [`WB_ADR_W-1:0] wb_adr_i,
    input  wire [`WB_DAT_W-1:0] wb_dat_i,
    output logic [`WB_DAT_W-1:0] wb_dat_o,
    output logic                wb_ack_o,
    cfg_if.regs                 cfg
);

    localparam logic [`WB_DAT_W-1:0] MODE_RST = 8'h04;   // Blanking on
    localparam logic [`WB_DAT_W-1:0] SYNC_RST = 8'h00;

    // MODE and SYNC bit positions
    localparam int MODE_YPBPR = 0;
    localparam int MODE_CSYNC = 1;
    localparam int MODE_BLANK = 2;
    localparam int SYNC_HINV  = 0;
    localparam int SYNC_VINV  = 1;

    wb_pkg::wb_state_e   state_q;
    logic [`WB_DAT_W-1:0] mode_q;
    logic [`WB_DAT_W-1:0] sync_q;
    logic [`WB_DAT_W-1:0] dat_q;
    logic [`WB_DAT_W-1:0] rd_map [`WB_REG_NUM];
    logic                 req;

    assign req = wb_cyc_i && wb_stb_i;

    // Read view of every address slot
    always_comb begin
        for (int i = 0; i < `WB_REG_NUM; i++) begin
            rd_map[i] = '0;
        end
        rd_map[wb_pkg::REG_MODE] = mode_q;
        rd_map[wb_pkg::REG_SYNC] = sync_q;
        rd_map[wb_pkg::REG_ID]   = `CORE_ID;
    end

    always_ff @(posedge clk_rgb) begin
        if (!rst_n_i) begin
            state_q <= wb_pkg::WB_IDLE;
            mode_q  <= MODE_RST;
            sync_q  <= SYNC_RST;
        end else begin
            case (state_q)
                wb_pkg::WB_IDLE: begin
                    if (req) begin
                        state_q <= wb_pkg::WB_ACK;
                        if (wb_we_i) begin
                            case (wb_pkg::reg_addr_e'(wb_adr_i))
                                wb_pkg::REG_MODE: mode_q <= wb_dat_i;
                                wb_pkg::REG_SYNC: sync_q <= wb_dat_i;
                                default: ;   // ID and slot 3 are read-only
                            endcase
                        end
                    end
                end
                default: state_q <= wb_pkg::WB_IDLE;  // Ack lasts one cycle
            endcase
        end
    end

    // Read data lands together with ack
    always_ff @(posedge clk_rgb) begin
        if (state_q == wb_pkg::WB_IDLE && req) begin
            dat_q <= rd_map[wb_adr_i];
        end
    end

    assign wb_ack_o = (state_q == wb_pkg::WB_ACK);
    assign wb_dat_o = dat_q;

    assign cfg.mode     = mode_q[MODE_YPBPR] ? video_pkg::OUT_YPBPR : video_pkg::OUT_RGB;
    assign cfg.csync_en = mode_q[MODE_CSYNC];
    assign cfg.blank_en = mode_q[MODE_BLANK];
    assign cfg.hs_inv   = sync_q[SYNC_HINV];
    assign cfg.vs_inv   = sync_q[SYNC_VINV];

endmodule

`default_nettype wire

// ==== design/pix_capture.sv ====
// Pixel capture and widening

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module pix_capture (
    input  wire                 clk_rgb,
    input  wire                 rst_n_i,
    input  wire                 cen_i,
    input  wire [`VID_IN_W-1:0] red_i,
    input  wire [`VID_IN_W-1:0] green_i,
    input  wire [`VID_IN_W-1:0] blue_i,
    input  wire                 lhbl_i,
    input  wire                 lvbl_i,
    input  wire                 hs_i,
    input  wire                 vs_i,
    cfg_if.user                 cfg,
    pix_if.src                  to_conv,
    pix_if.src                  to_mux
);

    // Repeat the top bits into the new low bits
    function automatic logic [`VID_OUT_W-1:0] widen(input logic [`VID_IN_W-1:0] c);
        return {c, c[`VID_IN_W-1 -: (`VID_OUT_W - `VID_IN_W)]};
    endfunction

    video_pkg::rgb6_t pix_d;
    video_pkg::rgb6_t pix_q;
    logic             hs_q;
    logic             vs_q;
    logic             blank;

    assign blank = cfg.blank_en && (!lhbl_i || !lvbl_i);

    always_comb begin
        pix_d.r = blank ? '0 : widen(red_i);
        pix_d.g = blank ? '0 : widen(green_i);
        pix_d.b = blank ? '0 : widen(blue_i);
    end

    always_ff @(posedge clk_rgb) begin
        if (!rst_n_i) begin
            pix_q <= '0;
            hs_q  <= 1'b0;
            vs_q  <= 1'b0;
        end else if (cen_i) begin   // Sample once per pixel
            pix_q <= pix_d;
            hs_q  <= hs_i;
            vs_q  <= vs_i;
        end
    end

    assign to_conv.pix = pix_q;
    assign to_conv.hs  = hs_q;
    assign to_conv.vs  = vs_q;
    assign to_mux.pix  = pix_q;
    assign to_mux.hs   = hs_q;
    assign to_mux.vs   = vs_q;

endmodule

`default_nettype wire

// ==== design/ypbpr_conv.sv ====
// RGB to YPbPr converter

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module ypbpr_conv (
    input  wire clk_rgb,
    input  wire rst_n_i,
    pix_if.snk  src,
    pix_if.src  dst
);

    localparam int ACC_W = 16;
    localparam logic signed [ACC_W-1:0] C_MAX = ACC_W'((1 << `VID_OUT_W) - 1);
    localparam logic signed [ACC_W-1:0] C_MID = ACC_W'(1 << (`VID_OUT_W - 1));

    // Saturate into the unsigned output range
    function automatic logic [`VID_OUT_W-1:0] clamp(input logic signed [ACC_W-1:0] v);
        logic [`VID_OUT_W-1:0] res;
        if (v < 0) begin
            res = '0;
        end else if (v > C_MAX) begin
            res = '1;
        end else begin
            res = v[`VID_OUT_W-1:0];
        end
        return res;
    endfunction

    logic signed [ACC_W-1:0] r_s, g_s, b_s;
    logic signed [ACC_W-1:0] y_acc, pb_acc, pr_acc;
    video_pkg::rgb6_t        out_q;
    logic                    hs_q;
    logic                    vs_q;

    assign r_s = $signed({{(ACC_W - `VID_OUT_W){1'b0}}, src.pix.r});
    assign g_s = $signed({{(ACC_W - `VID_OUT_W){1'b0}}, src.pix.g});
    assign b_s = $signed({{(ACC_W - `VID_OUT_W){1'b0}}, src.pix.b});

    // Coefficients scaled by 256, arithmetic shift floors
    assign y_acc  = (16'sd77 * r_s + 16'sd150 * g_s + 16'sd29 * b_s) >>> 8;
    assign pb_acc = ((16'sd128 * b_s - 16'sd43 * r_s - 16'sd85 * g_s) >>> 8) + C_MID;
    assign pr_acc = ((16'sd128 * r_s - 16'sd107 * g_s - 16'sd21 * b_s) >>> 8) + C_MID;

    always_ff @(posedge clk_rgb) begin
        if (!rst_n_i) begin
            out_q <= '0;
            hs_q  <= 1'b0;
            vs_q  <= 1'b0;
        end else begin
            out_q.r <= clamp(pr_acc);   // Pr
            out_q.g <= clamp(y_acc);    // Y
            out_q.b <= clamp(pb_acc);   // Pb
            hs_q    <= src.hs;
            vs_q    <= src.vs;
        end
    end

    assign dst.pix = out_q;
    assign dst.hs  = hs_q;
    assign dst.vs  = vs_q;

endmodule

`default_nettype wire

// ==== design/video_mux.sv ====
// Output selection and sync shaping

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_mux (
    input  wire                   clk_rgb,
    input  wire                   rst_n_i,
    pix_if.snk                    rgb,
    pix_if.snk                    ypbpr,
    cfg_if.user                   cfg,
    output logic [`VID_OUT_W-1:0] vga_r_o,
    output logic [`VID_OUT_W-1:0] vga_g_o,
    output logic [`VID_OUT_W-1:0] vga_b_o,
    output logic                  vga_hs_o,
    output logic                  vga_vs_o
);

    video_pkg::rgb6_t rgb_d;    // Matches the converter latency
    video_pkg::rgb6_t col_sel;
    logic             is_ypbpr;
    logic             csync;
    logic             hs_x;
    logic             vs_x;

    assign is_ypbpr = (cfg.mode == video_pkg::OUT_YPBPR);
    assign csync    = cfg.csync_en || is_ypbpr;
    assign col_sel  = is_ypbpr ? ypbpr.pix : rgb_d;

    // Both modes take sync from the converter path
    assign hs_x = ypbpr.hs ^ cfg.hs_inv;
    assign vs_x = ypbpr.vs ^ cfg.vs_inv;

    always_ff @(posedge clk_rgb) begin
        if (!rst_n_i) begin
            rgb_d    <= '0;
            vga_r_o  <= '0;
            vga_g_o  <= '0;
            vga_b_o  <= '0;
            vga_hs_o <= 1'b0;
            vga_vs_o <= 1'b0;
        end else begin
            rgb_d   <= rgb.pix;
            vga_r_o <= col_sel.r;
            vga_g_o <= col_sel.g;
            vga_b_o <= col_sel.b;
            if (csync) begin
                vga_hs_o <= ~(hs_x ^ vs_x); // Composite sync on HS
                vga_vs_o <= 1'b1;           // SCART cable wants VS high
            end else begin
                vga_hs_o <= hs_x;
                vga_vs_o <= vs_x;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/video_out_top.sv ====
// Video output stage top

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_out_top (
    input  wire                   clk_rgb,
    input  wire                   rst_n_i,
    input  wire [`VID_IN_W-1:0]   red_i,
    input  wire [`VID_IN_W-1:0]   green_i,
    input  wire [`VID_IN_W-1:0]   blue_i,
    input  wire                   lhbl_i,
    input  wire                   lvbl_i,
    input  wire                   hs_i,
    input  wire                   vs_i,
    input  wire                   wb_cyc_i,
    input  wire                   wb_stb_i,
    input  wire                   wb_we_i,
    input  wire [`WB_ADR_W-1:0]   wb_adr_i,
    input  wire [`WB_DAT_W-1:0]   wb_dat_i,
    output wire [`WB_DAT_W-1:0]   wb_dat_o,
    output wire                   wb_ack_o,
    output wire                   cen6_o,
    output wire [`VID_OUT_W-1:0]  vga_r_o,
    output wire [`VID_OUT_W-1:0]  vga_g_o,
    output wire [`VID_OUT_W-1:0]  vga_b_o,
    output wire                   vga_hs_o,
    output wire                   vga_vs_o
);

    pix_if cap_to_conv ();
    pix_if cap_to_mux ();
    pix_if conv_to_mux ();  // Pr, Y, Pb in r, g, b
    cfg_if cfg_bus ();

    cen_div u_cen (
        .clk_rgb ( clk_rgb ),
        .rst_n_i ( rst_n_i ),
        .cen6_o  ( cen6_o  )
    );

    wb_cfg_regs u_regs (
        .clk_rgb  ( clk_rgb  ),
        .rst_n_i  ( rst_n_i  ),
        .wb_cyc_i ( wb_cyc_i ),
        .wb_stb_i ( wb_stb_i ),
        .wb_we_i  ( wb_we_i  ),
        .wb_adr_i ( wb_adr_i ),
        .wb_dat_i ( wb_dat_i ),
        .wb_dat_o ( wb_dat_o ),
        .wb_ack_o ( wb_ack_o ),
        .cfg      ( cfg_bus  )
    );

    pix_capture u_cap (
        .clk_rgb ( clk_rgb     ),
        .rst_n_i ( rst_n_i     ),
        .cen_i   ( cen6_o      ),
        .red_i   ( red_i       ),
        .green_i ( green_i     ),
        .blue_i  ( blue_i      ),
        .lhbl_i  ( lhbl_i      ),
        .lvbl_i  ( lvbl_i      ),
        .hs_i    ( hs_i        ),
        .vs_i    ( vs_i        ),
        .cfg     ( cfg_bus     ),
        .to_conv ( cap_to_conv ),
        .to_mux  ( cap_to_mux  )
    );

    ypbpr_conv u_conv (
        .clk_rgb ( clk_rgb     ),
        .rst_n_i ( rst_n_i     ),
        .src     ( cap_to_conv ),
        .dst     ( conv_to_mux )
    );

    video_mux u_mux (
        .clk_rgb  ( clk_rgb     ),
        .rst_n_i  ( rst_n_i     ),
        .rgb      ( cap_to_mux  ),
        .ypbpr    ( conv_to_mux ),
        .cfg      ( cfg_bus     ),
        .vga_r_o  ( vga_r_o     ),
        .vga_g_o  ( vga_g_o     ),
        .vga_b_o  ( vga_b_o     ),
        .vga_hs_o ( vga_hs_o    ),
        .vga_vs_o ( vga_vs_o    )
    );

endmodule

`default_nettype wire

// ==== dv/video_out_assert.sv ====
// Bus and strobe assertions

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_out_assert (
    input wire clk_rgb,
    input wire rst_n_i,
    input wire req_i,
    input wire ack_i,
    input wire cen_i
);

    int   gap_q;    // Cycles since the last strobe
    logic seen_q;   // First strobe already seen

    always_ff @(posedge clk_rgb) begin
        if (!rst_n_i) begin
            gap_q  <= 0;
            seen_q <= 1'b0;
        end else if (cen_i) begin
            gap_q  <= 0;
            seen_q <= 1'b1;
        end else begin
            gap_q <= gap_q + 1;
        end
    end

    ack_one_cycle: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else $error("Wishbone ack held for more than one cycle");

    ack_after_req: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
        (req_i && !ack_i) |=> ack_i)
        else $error("Wishbone ack missing one cycle after the strobe");

    ack_needs_req: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
        ack_i |-> $past(req_i))
        else $error("Wishbone ack without a preceding strobe");

    // Reset to first strobe is one cycle longer than the steady period
    cen_first: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
        (cen_i && !seen_q) |-> (gap_q == `CEN_DIV))
        else $error("First pixel strobe at the wrong edge after reset");

    cen_period: assert property (@(posedge clk_rgb) disable iff (!rst_n_i)
        (cen_i && seen_q) |-> (gap_q == `CEN_DIV - 1))
        else $error("Pixel strobe period differs from the divider ratio");

endmodule

bind wb_cfg_regs video_out_assert u_bus_assert (
    .clk_rgb ( clk_rgb              ),
    .rst_n_i ( rst_n_i              ),
    .req_i   ( wb_cyc_i && wb_stb_i ),
    .ack_i   ( wb_ack_o             ),
    .cen_i   ( 1'b0                 )
);

bind cen_div video_out_assert u_cen_assert (
    .clk_rgb ( clk_rgb ),
    .rst_n_i ( rst_n_i ),
    .req_i   ( 1'b0    ),
    .ack_i   ( 1'b0    ),
    .cen_i   ( cen6_o  )
);

`default_nettype wire

// ==== dv/video_out_tb.sv ====
// Video output stage testbench

`timescale 1ns/1ps
`default_nettype none

`include "video_settings.svh"

module video_out_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int N_CASES      = 20;
    localparam int CYC_PER_CASE = 24;   // Two writes, strobe wait, pipeline
    localparam int WB_SETUP_CYC = 80;   // Reset and register tests
    localparam int ACK_WAIT_MAX = 8;

    typedef struct packed {
        logic [`WB_DAT_W-1:0] mode;
        logic [`WB_DAT_W-1:0] sync;
        logic [`VID_IN_W-1:0] r;
        logic [`VID_IN_W-1:0] g;
        logic [`VID_IN_W-1:0] b;
        logic                 lhbl;
        logic                 lvbl;
        logic                 hs;
        logic                 vs;
        logic                 rnd;  // Colour taken from the LFSR
    } pix_case_t;

    // mode, sync, r, g, b, lhbl, lvbl, hs, vs, rnd
    localparam pix_case_t CASES [N_CASES] = '{
        '{8'h04, 8'h00, 4'hF, 4'h0, 4'h8, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h04, 8'h00, 4'h3, 4'hA, 4'h5, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
        '{8'h04, 8'h00, 4'hF, 4'hF, 4'hF, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h04, 8'h00, 4'h7, 4'h7, 4'h7, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
        '{8'h00, 8'h00, 4'h9, 4'h6, 4'hC, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0},
        '{8'h00, 8'h01, 4'h1, 4'h2, 4'h3, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
        '{8'h00, 8'h02, 4'h4, 4'h5, 4'h6, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h00, 8'h03, 4'hE, 4'hD, 4'hC, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{8'h02, 8'h00, 4'h8, 4'h8, 4'h8, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
        '{8'h06, 8'h01, 4'h2, 4'h4, 4'h6, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0},
        '{8'h05, 8'h00, 4'hF, 4'hF, 4'hF, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h05, 8'h00, 4'h0, 4'h0, 4'h0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},
        '{8'h05, 8'h00, 4'hF, 4'h0, 4'h0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{8'h01, 8'h02, 4'h0, 4'hF, 4'h0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0},
        '{8'h05, 8'h00, 4'h0, 4'h0, 4'hF, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h05, 8'h00, 4'h0, 4'h0, 4'h0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1},
        '{8'h05, 8'h03, 4'h0, 4'h0, 4'h0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1},
        '{8'h01, 8'h00, 4'h0, 4'h0, 4'h0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1},
        '{8'h00, 8'h00, 4'h0, 4'h0, 4'h0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
        '{8'h04, 8'h00, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1}
    };

    logic                  clk_rgb;
    logic                  rst_n;
    logic [`VID_IN_W-1:0]  red;
    logic [`VID_IN_W-1:0]  green;
    logic [`VID_IN_W-1:0]  blue;
    logic                  lhbl;
    logic                  lvbl;
    logic                  hs;
    logic                  vs;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`WB_ADR_W-1:0]  wb_adr;
    logic [`WB_DAT_W-1:0]  wb_dat_w;
    logic [`WB_DAT_W-1:0]  wb_dat_r;
    logic                  wb_ack;
    logic                  cen6;
    logic [`VID_OUT_W-1:0] vga_r;
    logic [`VID_OUT_W-1:0] vga_g;
    logic [`VID_OUT_W-1:0] vga_b;
    logic                  vga_hs;
    logic                  vga_vs;
    logic [7:0]            lfsr_state;

    video_out_top DUT (
        .clk_rgb  ( clk_rgb  ),
        .rst_n_i  ( rst_n    ),
        .red_i    ( red      ),
        .green_i  ( green    ),
        .blue_i   ( blue     ),
        .lhbl_i   ( lhbl     ),
        .lvbl_i   ( lvbl     ),
        .hs_i     ( hs       ),
        .vs_i     ( vs       ),
        .wb_cyc_i ( wb_cyc   ),
        .wb_stb_i ( wb_stb   ),
        .wb_we_i  ( wb_we    ),
        .wb_adr_i ( wb_adr   ),
        .wb_dat_i ( wb_dat_w ),
        .wb_dat_o ( wb_dat_r ),
        .wb_ack_o ( wb_ack   ),
        .cen6_o   ( cen6     ),
        .vga_r_o  ( vga_r    ),
        .vga_g_o  ( vga_g    ),
        .vga_b_o  ( vga_b    ),
        .vga_hs_o ( vga_hs   ),
        .vga_vs_o ( vga_vs   )
    );

    always #(CLK_PERIOD / 2) clk_rgb = ~clk_rgb;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_rgb6(input string name, input video_pkg::rgb6_t got,
                              input video_pkg::rgb6_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [`WB_DAT_W-1:0] got,
                              input logic [`WB_DAT_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // Taps 8, 6, 5, 4, new bit enters at the bottom
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_colour(output logic [`VID_IN_W-1:0] c);
        for (int i = 0; i < `VID_IN_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            c = {c[`VID_IN_W-2:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [`VID_OUT_W-1:0] widen_channel(input logic [`VID_IN_W-1:0] c);
        return {c, c[`VID_IN_W-1:`VID_IN_W-2]};
    endfunction

    function automatic logic [`VID_OUT_W-1:0] clamp6(input int v);
        if (v < 0) begin
            return '0;
        end
        if (v > (1 << `VID_OUT_W) - 1) begin
            return '1;
        end
        return `VID_OUT_W'(v);
    endfunction

    // Reference model of the whole stage for one pixel
    task automatic compute_expected(input pix_case_t c, output video_pkg::rgb6_t pix,
                                    output logic hs_e, output logic vs_e);
        video_pkg::rgb6_t wide;
        int               rv;
        int               gv;
        int               bv;
        logic             hx;
        logic             vx;
        wide.r = widen_channel(c.r);
        wide.g = widen_channel(c.g);
        wide.b = widen_channel(c.b);
        if (c.mode[2] && (!c.lhbl || !c.lvbl)) begin
            wide = '0;
        end
        rv = wide.r;
        gv = wide.g;
        bv = wide.b;
        if (c.mode[0]) begin
            pix.g = clamp6((77 * rv + 150 * gv + 29 * bv) >>> 8);
            pix.b = clamp6(((128 * bv - 43 * rv - 85 * gv) >>> 8) + 32);
            pix.r = clamp6(((128 * rv - 107 * gv - 21 * bv) >>> 8) + 32);
        end else begin
            pix = wide;
        end
        hx = c.hs ^ c.sync[0];
        vx = c.vs ^ c.sync[1];
        if (c.mode[1] || c.mode[0]) begin
            hs_e = ~(hx ^ vx);
            vs_e = 1'b1;
        end else begin
            hs_e = hx;
            vs_e = vx;
        end
    endtask

    // Called DRIVE_DLY after a rising edge, returns at the same phase
    task automatic bus_transfer(input logic we, input logic [`WB_ADR_W-1:0] adr,
                                input logic [`WB_DAT_W-1:0] wdat,
                                output logic [`WB_DAT_W-1:0] rdat);
        int   n;
        logic got_ack;
        n       = 0;
        got_ack = 1'b0;
        rdat    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        while (!got_ack) begin
            @(negedge clk_rgb);
            if (wb_ack) begin
                got_ack = 1'b1;
                rdat    = wb_dat_r;
            end else begin
                n++;
                if (n > ACK_WAIT_MAX) begin
                    report_failure("Wishbone ack never came after the strobe");
                end
            end
        end
        @(posedge clk_rgb);
        #DRIVE_DLY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [`WB_ADR_W-1:0] adr, input logic [`WB_DAT_W-1:0] d);
        logic [`WB_DAT_W-1:0] unused;
        bus_transfer(1'b1, adr, d, unused);
    endtask

    task automatic read_reg(input logic [`WB_ADR_W-1:0] adr, output logic [`WB_DAT_W-1:0] d);
        bus_transfer(1'b0, adr, '0, d);
    endtask

    task automatic wait_strobe();
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        while (!hit) begin
            @(negedge clk_rgb);
            if (cen6) begin
                hit = 1'b1;
            end else begin
                n++;
                if (n > `CEN_DIV + 1) begin
                    report_failure("Pixel strobe cen6_o stopped pulsing");
                end
            end
        end
    endtask

    initial begin
        #((N_CASES * CYC_PER_CASE + WB_SETUP_CYC) * CLK_PERIOD);
        report_failure("Watchdog expired before the tests finished");
    end

    initial begin
        pix_case_t            cur;
        video_pkg::rgb6_t     exp_pix;
        video_pkg::rgb6_t     got_pix;
        logic                 exp_hs;
        logic                 exp_vs;
        logic [`WB_DAT_W-1:0] rd;
        clk_rgb    = 1'b0;
        rst_n      = 1'b0;
        red        = '0;
        green      = '0;
        blue       = '0;
        lhbl       = 1'b1;
        lvbl       = 1'b1;
        hs         = 1'b0;
        vs         = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        lfsr_state = 8'd8;
        repeat (3) @(posedge clk_rgb);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // Reset values, then the strobe pattern edge by edge
        @(negedge clk_rgb);
        got_pix = {vga_r, vga_g, vga_b};
        check_sync("wb_ack_o", wb_ack, 1'b0);
        check_rgb6("vga rgb", got_pix, '0);
        check_sync("vga_hs_o", vga_hs, 1'b0);
        check_sync("vga_vs_o", vga_vs, 1'b0);
        for (int k = 1; k <= 2 * `CEN_DIV; k++) begin
            @(posedge clk_rgb);
            @(negedge clk_rgb);
            check_sync("cen6_o", cen6, (k % `CEN_DIV) == 0);
        end
        @(posedge clk_rgb);
        #DRIVE_DLY;

        read_reg(wb_pkg::REG_MODE, rd);
        check_byte("MODE reset", rd, 8'h04);
        read_reg(wb_pkg::REG_SYNC, rd);
        check_byte("SYNC reset", rd, 8'h00);
        read_reg(wb_pkg::REG_ID, rd);
        check_byte("ID", rd, `CORE_ID);
        write_reg(wb_pkg::REG_MODE, 8'hA5);
        read_reg(wb_pkg::REG_MODE, rd);
        check_byte("MODE readback", rd, 8'hA5);
        write_reg(wb_pkg::REG_SYNC, 8'h3C);
        read_reg(wb_pkg::REG_SYNC, rd);
        check_byte("SYNC readback", rd, 8'h3C);
        write_reg(wb_pkg::REG_ID, 8'h00);    // Read-only
        read_reg(wb_pkg::REG_ID, rd);
        check_byte("ID after write", rd, `CORE_ID);
        write_reg(2'd3, 8'hFF);
        read_reg(2'd3, rd);
        check_byte("unused slot", rd, 8'h00);

        for (int i = 0; i < N_CASES; i++) begin
            cur = CASES[i];
            if (cur.rnd) begin
                draw_colour(cur.r);
                draw_colour(cur.g);
                draw_colour(cur.b);
            end
            write_reg(wb_pkg::REG_MODE, cur.mode);
            write_reg(wb_pkg::REG_SYNC, cur.sync);
            red   = cur.r;
            green = cur.g;
            blue  = cur.b;
            lhbl  = cur.lhbl;
            lvbl  = cur.lvbl;
            hs    = cur.hs;
            vs    = cur.vs;
            wait_strobe();
            // Capture edge plus four, outputs hold until two edges later
            repeat (5) @(posedge clk_rgb);
            @(negedge clk_rgb);
            compute_expected(cur, exp_pix, exp_hs, exp_vs);
            got_pix = {vga_r, vga_g, vga_b};
            check_rgb6($sformatf("vga rgb case %0d", i), got_pix, exp_pix);
            check_sync($sformatf("vga_hs_o case %0d", i), vga_hs, exp_hs);
            check_sync($sformatf("vga_vs_o case %0d", i), vga_vs, exp_vs);
            @(posedge clk_rgb);
            #DRIVE_DLY;
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
design/video_pkg.sv
design/wb_pkg.sv
design/video_ifs.sv
design/cen_div.sv
design/wb_cfg_regs.sv
design/pix_capture.sv
design/ypbpr_conv.sv
design/video_mux.sv
design/video_out_top.sv
dv/video_out_assert.sv
dv/video_out_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video output testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module video_out_tb -o video_out_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/video_out_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
